// ==== source/execute_consts.svh ====
`ifndef EXECUTE_CONSTS_SVH
`define EXECUTE_CONSTS_SVH

// Datapath widths
`define XLEN        32
`define REG_ADDR_W  5
`define OPCODE_W    7
`define FUNCT3_W    3
`define FUNCT7_W    7
`define SHAMT_W     5

// RV32I major opcodes handled here
`define OPC_OP      7'b0110011
`define OPC_OP_IMM  7'b0010011
`define OPC_LUI     7'b0110111
`define OPC_AUIPC   7'b0010111
`define OPC_BRANCH  7'b1100011
`define OPC_JAL     7'b1101111
`define OPC_JALR    7'b1100111

// funct3 of the shift group
`define F3_SLL      3'b001
`define F3_SRx      3'b101

// Selects SUB over ADD and SRA over SRL
`define F7_ALT      7'b0100000

`endif

// ==== source/execute_pkg.sv ====
`include "execute_consts.svh"

package execute_pkg;

    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_SLT,
        ALU_SLTU,
        ALU_PASS_B
    } alu_op_t;

    // One decoded instruction with its operands
    typedef struct packed {
        logic [`OPCODE_W-1:0]   opcode;
        logic [`REG_ADDR_W-1:0] rd;
        logic [`FUNCT3_W-1:0]   funct3;
        logic [`FUNCT7_W-1:0]   funct7;
        logic [`XLEN-1:0]       imm;
        logic [`XLEN-1:0]       pc;
        logic [`XLEN-1:0]       rs1_val;
        logic [`XLEN-1:0]       rs2_val;
    } issue_t;

    // What the next stage sees
    typedef struct packed {
        logic [`REG_ADDR_W-1:0] rd;
        logic [`XLEN-1:0]       rd_val;
        logic [`XLEN-1:0]       inst_pc;
        logic [`XLEN-1:0]       jump_pc;
        logic                   jump;
    } result_t;

endpackage

// ==== source/stage_hold.sv ====
`timescale 1ns/1ps

module stage_hold #(
    parameter type payload_t = logic
) (
    input  logic     clk,
    input  logic     reset,
    input  logic     flush,
    input  logic     load,
    input  payload_t data_in,
    output logic     load_ready,
    input  logic     stall,
    output logic     valid,
    output payload_t data_out
);

    logic take;

    // Room when empty or when the current entry leaves this edge
    assign load_ready = !valid || !stall;
    assign take = load && load_ready;

    always_ff @(posedge clk) begin
        if (reset || flush) begin
            valid <= 1'b0;
        end else if (take) begin
            valid <= 1'b1;
        end else if (!stall) begin
            valid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (take) begin
            data_out <= data_in;
        end
    end

    // Feeder only pushes when told there is room
    assert property (@(posedge clk) disable iff (reset)
        load |-> load_ready);

endmodule

// ==== source/int_alu.sv ====
`timescale 1ns/1ps

`include "execute_consts.svh"

module int_alu (
    input  logic [`XLEN-1:0]      in_a,
    input  logic [`XLEN-1:0]      in_b,
    input  execute_pkg::alu_op_t  op,
    output logic [`XLEN-1:0]      result,
    output logic                  lt,
    output logic                  ltu,
    output logic                  eq
);

    logic [`XLEN-1:0] sum;
    logic [`XLEN-1:0] diff;

    assign sum = in_a + in_b;
    assign diff = in_a - in_b;

    // Flags are always live for the branch logic
    assign lt = $signed(in_a) < $signed(in_b);
    assign ltu = in_a < in_b;
    assign eq = in_a == in_b;

    always_comb begin
        case (op)
            execute_pkg::ALU_ADD: begin
                result = sum;
            end
            execute_pkg::ALU_SUB: begin
                result = diff;
            end
            execute_pkg::ALU_AND: begin
                result = in_a & in_b;
            end
            execute_pkg::ALU_OR: begin
                result = in_a | in_b;
            end
            execute_pkg::ALU_XOR: begin
                result = in_a ^ in_b;
            end
            execute_pkg::ALU_SLT: begin
                result = {{(`XLEN-1){1'b0}}, lt};
            end
            execute_pkg::ALU_SLTU: begin
                result = {{(`XLEN-1){1'b0}}, ltu};
            end
            execute_pkg::ALU_PASS_B: begin
                result = in_b;
            end
            default: begin
                result = '0;
            end
        endcase
    end

endmodule

// ==== source/alu_decode.sv ====
`timescale 1ns/1ps

`include "execute_consts.svh"

module alu_decode (
    input  logic [`OPCODE_W-1:0]   opcode,
    input  logic [`REG_ADDR_W-1:0] rd,
    input  logic [`FUNCT3_W-1:0]   funct3,
    input  logic [`FUNCT7_W-1:0]   funct7,
    input  logic [`XLEN-1:0]       imm,
    input  logic [`XLEN-1:0]       pc,
    input  logic [`XLEN-1:0]       rs1_val,
    input  logic [`XLEN-1:0]       rs2_val,
    input  logic [`XLEN-1:0]       alu_result,
    input  logic                   lt,
    input  logic                   ltu,
    input  logic                   eq,
    input  logic [`XLEN-1:0]       shift_result,
    output logic [`XLEN-1:0]       alu_a,
    output logic [`XLEN-1:0]       alu_b,
    output execute_pkg::alu_op_t   alu_op,
    output logic                   is_shift,
    output logic [`SHAMT_W-1:0]    shamt,
    output logic                   shift_left,
    output logic                   shift_arith,
    output logic [`XLEN-1:0]       rd_val,
    output logic [`XLEN-1:0]       jump_pc,
    output logic                   jump
);

    logic is_op;
    logic is_op_imm;
    logic is_lui;
    logic is_auipc;
    logic is_branch;
    logic is_jal;
    logic is_jalr;
    logic branch_taken;
    logic [`XLEN-1:0] link_pc;
    logic [`XLEN-1:0] branch_target;

    assign is_op = opcode == `OPC_OP;
    assign is_op_imm = opcode == `OPC_OP_IMM;
    assign is_lui = opcode == `OPC_LUI;
    assign is_auipc = opcode == `OPC_AUIPC;
    assign is_branch = opcode == `OPC_BRANCH;
    assign is_jal = opcode == `OPC_JAL;
    assign is_jalr = opcode == `OPC_JALR;

    assign is_shift = (is_op || is_op_imm) && (funct3 == `F3_SLL || funct3 == `F3_SRx);
    assign shift_left = funct3 == `F3_SLL;
    assign shift_arith = funct7 == `F7_ALT;
    // Register shifts take the low bits of rs2, immediate ones the shamt field
    assign shamt = is_op ? rs2_val[`SHAMT_W-1:0] : imm[`SHAMT_W-1:0];

    // The ALU is busy comparing during a branch, so the target has its own adder
    assign link_pc = pc + 4;
    assign branch_target = pc + imm;

    always_comb begin
        alu_a = rs1_val;
        alu_b = rs2_val;
        alu_op = execute_pkg::ALU_ADD;
        if (is_op || is_op_imm) begin
            if (is_op_imm) begin
                alu_b = imm;
            end
            case (funct3)
                3'b000: alu_op = (is_op && funct7 == `F7_ALT) ? execute_pkg::ALU_SUB
                                                               : execute_pkg::ALU_ADD;
                3'b010: alu_op = execute_pkg::ALU_SLT;
                3'b011: alu_op = execute_pkg::ALU_SLTU;
                3'b100: alu_op = execute_pkg::ALU_XOR;
                3'b110: alu_op = execute_pkg::ALU_OR;
                3'b111: alu_op = execute_pkg::ALU_AND;
                default: alu_op = execute_pkg::ALU_ADD;
            endcase
        end else if (is_branch) begin
            alu_op = execute_pkg::ALU_SUB;
        end else if (is_lui) begin
            alu_b = imm;
            alu_op = execute_pkg::ALU_PASS_B;
        end else if (is_auipc || is_jal) begin
            alu_a = pc;
            alu_b = imm;
        end else if (is_jalr) begin
            alu_b = imm;
        end
    end

    always_comb begin
        case (funct3)
            3'b000: branch_taken = eq;
            3'b001: branch_taken = !eq;
            3'b100: branch_taken = lt;
            3'b101: branch_taken = !lt;
            3'b110: branch_taken = ltu;
            3'b111: branch_taken = !ltu;
            default: branch_taken = 1'b0;
        endcase
    end

    always_comb begin
        rd_val = '0;
        jump_pc = '0;
        jump = 1'b0;
        if (is_shift) begin
            rd_val = shift_result;
        end else if (is_op || is_op_imm || is_lui || is_auipc) begin
            rd_val = alu_result;
        end else if (is_jal || is_jalr) begin
            rd_val = link_pc;
            jump = 1'b1;
            jump_pc = is_jalr ? {alu_result[`XLEN-1:1], 1'b0} : alu_result;
        end else if (is_branch && branch_taken) begin
            jump = 1'b1;
            jump_pc = branch_target;
        end
        // x0 is hardwired to zero
        if (rd == '0) begin
            rd_val = '0;
        end
    end

endmodule

// ==== source/serial_shifter.sv ====
`timescale 1ns/1ps

`include "execute_consts.svh"

module serial_shifter (
    input  logic                clk,
    input  logic                reset,
    input  logic                flush,
    input  logic                start,
    input  logic [`XLEN-1:0]    value,
    input  logic [`SHAMT_W-1:0] shamt,
    input  logic                left,
    input  logic                arith,
    output logic                busy,
    output logic                done,
    output logic [`XLEN-1:0]    result
);

    logic [`SHAMT_W-1:0] count;
    logic [`XLEN-1:0] shift_reg;
    logic left_q;
    logic arith_q;
    logic fill;

    // Finished once the count has run out
    assign done = busy && count == '0;
    assign result = shift_reg;
    assign fill = arith_q && shift_reg[`XLEN-1];

    always_ff @(posedge clk) begin
        if (reset || flush) begin
            busy <= 1'b0;
            count <= '0;
        end else if (start) begin
            busy <= 1'b1;
            count <= shamt;
        end else if (busy) begin
            if (count == '0) begin
                busy <= 1'b0;
            end else begin
                count <= count - 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (start) begin
            shift_reg <= value;
            left_q <= left;
            arith_q <= arith;
        end else if (busy && count != '0) begin
            if (left_q) begin
                shift_reg <= {shift_reg[`XLEN-2:0], 1'b0};
            end else begin
                shift_reg <= {fill, shift_reg[`XLEN-1:1]};
            end
        end
    end

    assert property (@(posedge clk) disable iff (reset || flush)
        start |-> !busy);

endmodule

// ==== source/execute_stage.sv ====
`timescale 1ns/1ps

`include "execute_consts.svh"

module execute_stage (
    input  logic                   clk,
    input  logic                   reset,
    input  logic                   flush,
    input  logic [`OPCODE_W-1:0]   decode_opcode,
    input  logic [`REG_ADDR_W-1:0] decode_rd,
    input  logic [`FUNCT3_W-1:0]   decode_funct3,
    input  logic [`FUNCT7_W-1:0]   decode_funct7,
    input  logic [`XLEN-1:0]       decode_imm,
    input  logic [`XLEN-1:0]       decode_pc,
    input  logic [`XLEN-1:0]       read_rs1_val,
    input  logic [`XLEN-1:0]       read_rs2_val,
    input  logic                   read_valid,
    output logic                   read_stall,
    input  logic                   stall,
    output logic                   valid,
    output logic [`REG_ADDR_W-1:0] rd_out,
    output logic [`XLEN-1:0]       rd_val_out,
    output logic [`XLEN-1:0]       inst_pc_out,
    output logic [`XLEN-1:0]       jump_pc_out,
    output logic                   jump_out
);

    execute_pkg::issue_t issue_in;
    execute_pkg::issue_t issue_q;
    execute_pkg::result_t result_in;
    execute_pkg::result_t result_q;

    logic issue_load;
    logic issue_ready;
    logic issue_valid;
    logic issue_stall;
    logic result_ready;
    logic result_fire;
    logic first_cycle;
    logic shift_start;
    logic shift_done_q;
    logic shift_complete;

    logic [`XLEN-1:0] alu_a;
    logic [`XLEN-1:0] alu_b;
    execute_pkg::alu_op_t alu_op;
    logic [`XLEN-1:0] alu_result;
    logic alu_lt;
    logic alu_ltu;
    logic alu_eq;

    logic is_shift;
    logic [`SHAMT_W-1:0] shamt;
    logic shift_left;
    logic shift_arith;
    logic shift_busy;
    logic shift_done;
    logic [`XLEN-1:0] shift_result;

    logic [`XLEN-1:0] rd_val;
    logic [`XLEN-1:0] jump_pc;
    logic jump;

    assign issue_in = '{
        opcode: decode_opcode,
        rd: decode_rd,
        funct3: decode_funct3,
        funct7: decode_funct7,
        imm: decode_imm,
        pc: decode_pc,
        rs1_val: read_rs1_val,
        rs2_val: read_rs2_val
    };

    assign read_stall = !issue_ready;
    assign issue_load = read_valid && !read_stall;

    stage_hold #(.payload_t(execute_pkg::issue_t)) issue_hold (
        .clk(clk),
        .reset(reset),
        .flush(flush),
        .load(issue_load),
        .data_in(issue_in),
        .load_ready(issue_ready),
        .stall(issue_stall),
        .valid(issue_valid),
        .data_out(issue_q)
    );

    alu_decode decode (
        .opcode(issue_q.opcode),
        .rd(issue_q.rd),
        .funct3(issue_q.funct3),
        .funct7(issue_q.funct7),
        .imm(issue_q.imm),
        .pc(issue_q.pc),
        .rs1_val(issue_q.rs1_val),
        .rs2_val(issue_q.rs2_val),
        .alu_result(alu_result),
        .lt(alu_lt),
        .ltu(alu_ltu),
        .eq(alu_eq),
        .shift_result(shift_result),
        .alu_a(alu_a),
        .alu_b(alu_b),
        .alu_op(alu_op),
        .is_shift(is_shift),
        .shamt(shamt),
        .shift_left(shift_left),
        .shift_arith(shift_arith),
        .rd_val(rd_val),
        .jump_pc(jump_pc),
        .jump(jump)
    );

    int_alu alu (
        .in_a(alu_a),
        .in_b(alu_b),
        .op(alu_op),
        .result(alu_result),
        .lt(alu_lt),
        .ltu(alu_ltu),
        .eq(alu_eq)
    );

    // Kick the shifter once, on the first cycle the shift sits in the hold
    assign shift_start = first_cycle && is_shift;

    serial_shifter shifter (
        .clk(clk),
        .reset(reset),
        .flush(flush),
        .start(shift_start),
        .value(issue_q.rs1_val),
        .shamt(shamt),
        .left(shift_left),
        .arith(shift_arith),
        .busy(shift_busy),
        .done(shift_done),
        .result(shift_result)
    );

    // done is a pulse, so remember it if the output side was stalled
    assign shift_complete = shift_done || shift_done_q;
    assign result_fire = issue_valid && (!is_shift || shift_complete) && result_ready;
    assign issue_stall = !result_fire;

    always_ff @(posedge clk) begin
        if (reset || flush) begin
            first_cycle <= 1'b0;
            shift_done_q <= 1'b0;
        end else begin
            first_cycle <= issue_load;
            if (result_fire) begin
                shift_done_q <= 1'b0;
            end else if (shift_done) begin
                shift_done_q <= 1'b1;
            end
        end
    end

    assign result_in = '{
        rd: issue_q.rd,
        rd_val: rd_val,
        inst_pc: issue_q.pc,
        jump_pc: jump_pc,
        jump: jump
    };

    stage_hold #(.payload_t(execute_pkg::result_t)) result_hold (
        .clk(clk),
        .reset(reset),
        .flush(flush),
        .load(result_fire),
        .data_in(result_in),
        .load_ready(result_ready),
        .stall(stall),
        .valid(valid),
        .data_out(result_q)
    );

    assign rd_out = result_q.rd;
    assign rd_val_out = result_q.rd_val;
    assign inst_pc_out = result_q.inst_pc;
    assign jump_pc_out = result_q.jump_pc;
    assign jump_out = valid && result_q.jump;

    // A waiting shift past its first cycle must still be in the shifter
    assert property (@(posedge clk) disable iff (reset || flush)
        issue_valid && is_shift && !first_cycle && !shift_complete |-> shift_busy);

endmodule

// ==== test/execute_tb.sv ====
`timescale 1ns/1ps

`include "execute_consts.svh"

module execute_tb;

    localparam int alu_n = 40;
    localparam int br_n = 36;
    localparam int jmp_n = 8;
    localparam int sh_n = 15;
    localparam int bp_n = 24;
    // Worst case per instruction, plus reset, the flush test and some slack
    localparam int timeout_cycles = 16 + (alu_n + br_n + jmp_n) * 6 + sh_n * 40
                                    + bp_n * 50 + 80 + 200;

    logic clk;
    logic reset;
    logic flush;
    logic [`OPCODE_W-1:0] decode_opcode;
    logic [`REG_ADDR_W-1:0] decode_rd;
    logic [`FUNCT3_W-1:0] decode_funct3;
    logic [`FUNCT7_W-1:0] decode_funct7;
    logic [`XLEN-1:0] decode_imm;
    logic [`XLEN-1:0] decode_pc;
    logic [`XLEN-1:0] read_rs1_val;
    logic [`XLEN-1:0] read_rs2_val;
    logic read_valid;
    logic read_stall;
    logic stall = 1'b0;
    logic valid;
    logic [`REG_ADDR_W-1:0] rd_out;
    logic [`XLEN-1:0] rd_val_out;
    logic [`XLEN-1:0] inst_pc_out;
    logic [`XLEN-1:0] jump_pc_out;
    logic jump_out;

    execute_pkg::result_t expected[$];
    execute_pkg::result_t mon_actual;
    execute_pkg::result_t mon_exp;
    execute_pkg::result_t prev_out;
    logic prev_valid = 1'b0;
    logic prev_stall = 1'b0;
    logic stall_level = 1'b0;
    int cycle = 0;
    int accept_cycle = 0;
    int appear_cycle = 0;
    int stall_mode = 0;
    int span = 0;
    int checks = 0;
    int errors = 0;
    int tests = 0;
    int errors_at_start = 0;
    string test_name = "reset";

    execute_stage dut (
        .clk(clk),
        .reset(reset),
        .flush(flush),
        .decode_opcode(decode_opcode),
        .decode_rd(decode_rd),
        .decode_funct3(decode_funct3),
        .decode_funct7(decode_funct7),
        .decode_imm(decode_imm),
        .decode_pc(decode_pc),
        .read_rs1_val(read_rs1_val),
        .read_rs2_val(read_rs2_val),
        .read_valid(read_valid),
        .read_stall(read_stall),
        .stall(stall),
        .valid(valid),
        .rd_out(rd_out),
        .rd_val_out(rd_val_out),
        .inst_pc_out(inst_pc_out),
        .jump_pc_out(jump_pc_out),
        .jump_out(jump_out)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    always @(posedge clk) begin
        cycle <= cycle + 1;
    end

    initial begin
        while (cycle < timeout_cycles) @(posedge clk);
        $display("Timeout: no finish after %0d cycles in test %s", cycle, test_name);
        $display("TB FAILED");
        $finish;
    end

    function automatic string fmt_result(input execute_pkg::result_t r);
        return $sformatf("rd=%0d rd_val=%h pc=%h jump_pc=%h jump=%b",
                         r.rd, r.rd_val, r.inst_pc, r.jump_pc, r.jump);
    endfunction

    task automatic check_result(input string name, input execute_pkg::result_t exp,
                                input execute_pkg::result_t act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("[FAIL] %s: expected %s, actual %s", name, fmt_result(exp),
                     fmt_result(act));
        end
    endtask

    task automatic check_bit(input string name, input logic exp, input logic act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("[FAIL] %s: expected %b, actual %b", name, exp, act);
        end
    endtask

    task automatic check_count(input string name, input int exp, input int act);
        checks++;
        if (act != exp) begin
            errors++;
            $display("[FAIL] %s: expected %0d, actual %0d", name, exp, act);
        end
    endtask

    // RV32I rules for the instructions this stage handles
    function automatic execute_pkg::result_t expected_result(input execute_pkg::issue_t in);
        execute_pkg::result_t r;
        logic [31:0] b;
        logic [31:0] tgt;
        logic taken;
        r = '0;
        r.rd = in.rd;
        r.inst_pc = in.pc;
        b = (in.opcode == `OPC_OP) ? in.rs2_val : in.imm;
        taken = 1'b0;
        case (in.opcode)
            `OPC_OP, `OPC_OP_IMM: begin
                case (in.funct3)
                    3'b000: begin
                        if (in.opcode == `OPC_OP && in.funct7 == `F7_ALT) begin
                            r.rd_val = in.rs1_val - b;
                        end else begin
                            r.rd_val = in.rs1_val + b;
                        end
                    end
                    3'b001: r.rd_val = in.rs1_val << b[4:0];
                    3'b010: r.rd_val = ($signed(in.rs1_val) < $signed(b)) ? 32'd1 : 32'd0;
                    3'b011: r.rd_val = (in.rs1_val < b) ? 32'd1 : 32'd0;
                    3'b100: r.rd_val = in.rs1_val ^ b;
                    3'b101: begin
                        if (in.funct7 == `F7_ALT) begin
                            r.rd_val = $signed(in.rs1_val) >>> b[4:0];
                        end else begin
                            r.rd_val = in.rs1_val >> b[4:0];
                        end
                    end
                    3'b110: r.rd_val = in.rs1_val | b;
                    default: r.rd_val = in.rs1_val & b;
                endcase
            end
            `OPC_LUI: r.rd_val = in.imm;
            `OPC_AUIPC: r.rd_val = in.pc + in.imm;
            `OPC_JAL, `OPC_JALR: begin
                r.rd_val = in.pc + 32'd4;
                r.jump = 1'b1;
                tgt = (in.opcode == `OPC_JAL) ? in.pc + in.imm : in.rs1_val + in.imm;
                r.jump_pc = (in.opcode == `OPC_JAL) ? tgt : {tgt[31:1], 1'b0};
            end
            `OPC_BRANCH: begin
                case (in.funct3)
                    3'b000: taken = in.rs1_val == in.rs2_val;
                    3'b001: taken = in.rs1_val != in.rs2_val;
                    3'b100: taken = $signed(in.rs1_val) < $signed(in.rs2_val);
                    3'b101: taken = $signed(in.rs1_val) >= $signed(in.rs2_val);
                    3'b110: taken = in.rs1_val < in.rs2_val;
                    3'b111: taken = in.rs1_val >= in.rs2_val;
                    default: taken = 1'b0;
                endcase
                r.jump = taken;
                r.jump_pc = taken ? in.pc + in.imm : 32'd0;
            end
            default: r.rd_val = 32'd0;
        endcase
        // Writes to x0 are dropped
        if (in.rd == 5'd0) begin
            r.rd_val = 32'd0;
        end
        return r;
    endfunction

    function automatic execute_pkg::issue_t make_issue(input logic [6:0] opcode,
            input logic [4:0] rd, input logic [2:0] f3, input logic [6:0] f7,
            input logic [31:0] imm, input logic [31:0] pc, input logic [31:0] rs1,
            input logic [31:0] rs2);
        execute_pkg::issue_t in;
        in.opcode = opcode;
        in.rd = rd;
        in.funct3 = f3;
        in.funct7 = f7;
        in.imm = imm;
        in.pc = pc;
        in.rs1_val = rs1;
        in.rs2_val = rs2;
        return in;
    endfunction

    function automatic logic [31:0] imm12();
        logic [11:0] r;
        r = 12'($urandom);
        return {{20{r[11]}}, r};
    endfunction

    function automatic logic [31:0] random_pc();
        return $urandom & 32'hffff_fffc;
    endfunction

    // kind 0 is SLL, 1 is SRL, 2 is SRA
    function automatic execute_pkg::issue_t random_shift(input int kind,
            input logic [4:0] amount, input logic use_imm);
        logic [2:0] f3;
        logic [6:0] f7;
        logic [4:0] rd;
        f3 = (kind == 0) ? `F3_SLL : `F3_SRx;
        f7 = (kind == 2) ? `F7_ALT : 7'd0;
        rd = 5'(1 + $urandom % 31);
        if (use_imm) begin
            return make_issue(`OPC_OP_IMM, rd, f3, f7, {20'd0, f7, amount}, random_pc(),
                              $urandom, $urandom);
        end
        return make_issue(`OPC_OP, rd, f3, f7, 32'd0, random_pc(), $urandom,
                          ($urandom & 32'hffff_ffe0) | {27'd0, amount});
    endfunction

    function automatic execute_pkg::issue_t random_alu(input logic with_shifts);
        logic [2:0] f3_list [6];
        logic [2:0] f3;
        logic [6:0] f7;
        int kind;
        f3_list = '{3'b000, 3'b010, 3'b011, 3'b100, 3'b110, 3'b111};
        kind = int'($urandom % (with_shifts ? 5 : 4));
        f3 = f3_list[$urandom % 6];
        f7 = (f3 == 3'b000 && $urandom % 2 == 0) ? `F7_ALT : 7'd0;
        case (kind)
            0: return make_issue(`OPC_OP, 5'($urandom), f3, f7, 32'd0, random_pc(),
                                 $urandom, $urandom);
            1: return make_issue(`OPC_OP_IMM, 5'($urandom), f3, 7'd0, imm12(),
                                 random_pc(), $urandom, $urandom);
            2: return make_issue(`OPC_LUI, 5'($urandom), 3'd0, 7'd0,
                                 $urandom & 32'hffff_f000, random_pc(), $urandom, $urandom);
            3: return make_issue(`OPC_AUIPC, 5'($urandom), 3'd0, 7'd0,
                                 $urandom & 32'hffff_f000, random_pc(), $urandom, $urandom);
            default: return random_shift(int'($urandom % 3), 5'($urandom), 1'($urandom));
        endcase
    endfunction

    // Holds the instruction on the inputs until the stage takes it
    task automatic issue(input execute_pkg::issue_t in);
        logic ready;
        ready = 1'b0;
        while (!ready) begin
            @(negedge clk);
            decode_opcode = in.opcode;
            decode_rd = in.rd;
            decode_funct3 = in.funct3;
            decode_funct7 = in.funct7;
            decode_imm = in.imm;
            decode_pc = in.pc;
            read_rs1_val = in.rs1_val;
            read_rs2_val = in.rs2_val;
            read_valid = 1'b1;
            #1;
            ready = !read_stall;
            @(posedge clk);
        end
        expected.push_back(expected_result(in));
        @(negedge clk);
        read_valid = 1'b0;
        accept_cycle = cycle;
    endtask

    task automatic drain();
        while (expected.size() != 0) @(negedge clk);
        @(negedge clk);
    endtask

    task automatic open_test(input string name);
        test_name = name;
        errors_at_start = errors;
    endtask

    task automatic close_test();
        tests++;
        $display("Test %s finished with %0d errors", test_name, errors - errors_at_start);
    endtask

    // Watches the outputs, drives stall and checks what is taken
    always @(negedge clk) begin
        if (!reset) begin
            mon_actual.rd = rd_out;
            mon_actual.rd_val = rd_val_out;
            mon_actual.inst_pc = inst_pc_out;
            mon_actual.jump_pc = jump_pc_out;
            mon_actual.jump = jump_out;
            if (prev_valid && prev_stall) begin
                check_bit({test_name, " held valid"}, 1'b1, valid);
                check_result({test_name, " held result"}, prev_out, mon_actual);
            end else if (valid) begin
                appear_cycle = cycle;
            end
            if (stall_mode == 0) begin
                stall = 1'b0;
            end else if (stall_mode == 2) begin
                stall = 1'b1;
            end else begin
                if (span == 0) begin
                    stall_level = 1'($urandom);
                    span = 1 + int'($urandom % 6);
                end
                span--;
                stall = stall_level;
            end
            if (valid && !stall) begin
                if (expected.size() == 0) begin
                    errors++;
                    $display("Result appeared with no instruction pending in test %s",
                             test_name);
                end else begin
                    mon_exp = expected.pop_front();
                    check_result(test_name, mon_exp, mon_actual);
                end
            end
            prev_valid = valid;
            prev_stall = stall;
            prev_out = mon_actual;
        end
    end

    task automatic alu_ops();
        int i;
        open_test("alu");
        for (i = 0; i < alu_n; i++) begin
            issue(random_alu(1'b0));
        end
        drain();
        close_test();
    endtask

    task automatic branch_ops();
        logic [2:0] f3_list [6];
        logic [31:0] a;
        logic [31:0] b;
        logic [12:0] r;
        int i;
        f3_list = '{3'b000, 3'b001, 3'b100, 3'b101, 3'b110, 3'b111};
        open_test("branches");
        for (i = 0; i < br_n; i++) begin
            a = $urandom;
            case ($urandom % 3)
                0: b = a;
                1: b = a ^ 32'h8000_0000;
                default: b = $urandom;
            endcase
            r = 13'($urandom);
            issue(make_issue(`OPC_BRANCH, 5'd0, f3_list[i % 6], 7'd0,
                             {{19{r[12]}}, r[12:1], 1'b0}, random_pc(), a, b));
        end
        drain();
        close_test();
    endtask

    task automatic jump_ops();
        logic [20:0] r;
        int i;
        open_test("jumps");
        for (i = 0; i < jmp_n; i++) begin
            r = 21'($urandom);
            if (i % 2 == 0) begin
                issue(make_issue(`OPC_JAL, 5'(1 + i), 3'd0, 7'd0,
                                 {{11{r[20]}}, r[20:1], 1'b0}, random_pc(), $urandom, 32'd0));
            end else begin
                issue(make_issue(`OPC_JALR, 5'(1 + i), 3'd0, 7'd0, imm12(), random_pc(),
                                 $urandom, 32'd0));
            end
        end
        drain();
        close_test();
    endtask

    task automatic shift_ops();
        logic [4:0] amounts [5];
        int k;
        int a;
        amounts = '{5'd0, 5'd1, 5'd31, 5'($urandom), 5'($urandom)};
        open_test("shifts");
        for (k = 0; k < 3; k++) begin
            for (a = 0; a < 5; a++) begin
                issue(random_shift(k, amounts[a], 1'(a % 2)));
                drain();
                check_count($sformatf("shift latency, amount %0d", amounts[a]),
                            2 + int'(amounts[a]), appear_cycle - accept_cycle);
            end
        end
        close_test();
    endtask

    task automatic stall_spans();
        int i;
        open_test("back-pressure");
        stall_mode = 2;
        issue(random_alu(1'b0));
        issue(random_alu(1'b0));
        #1;
        check_bit("back-pressure read_stall", 1'b1, read_stall);
        stall_mode = 1;
        for (i = 0; i < bp_n; i++) begin
            issue(random_alu(1'b1));
        end
        drain();
        stall_mode = 0;
        close_test();
    endtask

    task automatic flush_shift();
        open_test("flush");
        // A stalled result waits in the output hold while the shift runs behind it
        stall_mode = 2;
        issue(make_issue(`OPC_OP_IMM, 5'd3, 3'b000, 7'd0, 32'd1, random_pc(), $urandom,
                         32'd0));
        issue(make_issue(`OPC_OP, 5'd7, `F3_SLL, 7'd0, 32'd0, random_pc(), $urandom, 32'd31));
        repeat (6) @(negedge clk);
        flush = 1'b1;
        // Both holds are emptied, so nothing may come out for either instruction
        expected.delete();
        @(posedge clk);
        #1;
        prev_valid = 1'b0;
        @(negedge clk);
        flush = 1'b0;
        stall_mode = 0;
        check_bit("flush valid", 1'b0, valid);
        check_bit("flush read_stall", 1'b0, read_stall);
        repeat (40) @(negedge clk);
        issue(make_issue(`OPC_OP_IMM, 5'd9, 3'b000, 7'd0, 32'd5, random_pc(), $urandom,
                         32'd0));
        drain();
        close_test();
    endtask

    initial begin
        void'($urandom(36622));
        reset = 1'b1;
        flush = 1'b0;
        decode_opcode = '0;
        decode_rd = '0;
        decode_funct3 = '0;
        decode_funct7 = '0;
        decode_imm = '0;
        decode_pc = '0;
        read_rs1_val = '0;
        read_rs2_val = '0;
        read_valid = 1'b0;
        repeat (16) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;

        open_test("reset");
        check_bit("reset valid", 1'b0, valid);
        check_bit("reset read_stall", 1'b0, read_stall);
        check_bit("reset jump", 1'b0, jump_out);
        close_test();

        alu_ops();
        branch_ops();
        jump_ops();
        shift_ops();
        stall_spans();
        flush_shift();

        $display("Tests run: %0d, checks: %0d, errors: %0d", tests, checks, errors);
        if (errors == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

endmodule

// ==== project.f ====
+incdir+source
source/execute_pkg.sv
source/stage_hold.sv
source/int_alu.sv
source/alu_decode.sv
source/serial_shifter.sv
source/execute_stage.sv
test/execute_tb.sv

// ==== run.sh ====
#!/usr/bin/env bash
# Build and run the execute stage testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal -f project.f \
    --top-module execute_tb -Mdir obj_dir -o sim_execute
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/sim_execute > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "TB FAILED" sim.log; then
    echo "Simulation reported failure"
    exit 1
fi

exit 0
